// File: hdl/axis_skid_buffer.sv
// output skid buffer: registered stream stage with a temp entry and early ready
`timescale 1ns/1ps
`default_nettype none

`include "mac_ctrl_settings.svh"

module axis_skid_buffer (
    input  wire logic                   clk,
    input  wire logic                   rst,

    // beats from the scheduler
    input  wire logic [`MCF_DATA_W-1:0] int_data,
    input  wire logic [`MCF_KEEP_W-1:0] int_keep,
    input  wire logic                   int_valid,
    input  wire logic                   int_last,
    output logic                        ready_early,
    output logic                        ready_reg,

    // registered output stream
    output logic [`MCF_DATA_W-1:0]      m_axis_tdata,
    output logic [`MCF_KEEP_W-1:0]      m_axis_tkeep,
    output logic                        m_axis_tvalid,
    input  wire logic                   m_axis_tready,
    output logic                        m_axis_tlast
);

    // output entry
    logic [`MCF_DATA_W-1:0] out_data_reg;
    logic [`MCF_KEEP_W-1:0] out_keep_reg;
    logic                   out_last_reg;
    logic                   out_valid_reg, out_valid_next;

    // temp entry, only used under back-pressure
    logic [`MCF_DATA_W-1:0] tmp_data_reg;
    logic [`MCF_KEEP_W-1:0] tmp_keep_reg;
    logic                   tmp_last_reg;
    logic                   tmp_valid_reg, tmp_valid_next;

    logic                   int_to_out;
    logic                   int_to_tmp;
    logic                   tmp_to_out;

    assign m_axis_tdata  = out_data_reg;
    assign m_axis_tkeep  = out_keep_reg;
    assign m_axis_tvalid = out_valid_reg;
    assign m_axis_tlast  = out_last_reg;

    // ready next cycle unless temp could fill up
    assign ready_early = m_axis_tready ||
                         (!tmp_valid_reg && (!out_valid_reg || !int_valid));

    always_comb begin
        out_valid_next = out_valid_reg;
        tmp_valid_next = tmp_valid_reg;
        int_to_out     = 1'b0;
        int_to_tmp     = 1'b0;
        tmp_to_out     = 1'b0;

        if (ready_reg) begin
            if (m_axis_tready || !out_valid_reg) begin
                // output free or draining
                out_valid_next = int_valid;
                int_to_out     = 1'b1;
            end else begin
                tmp_valid_next = int_valid;
                int_to_tmp     = 1'b1;
            end
        end else if (m_axis_tready) begin
            // no input this cycle, drain temp into output
            out_valid_next = tmp_valid_reg;
            tmp_valid_next = 1'b0;
            tmp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg <= 1'b0;
            tmp_valid_reg <= 1'b0;
            ready_reg     <= 1'b0;
        end else begin
            out_valid_reg <= out_valid_next;
            tmp_valid_reg <= tmp_valid_next;
            ready_reg     <= ready_early;
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (int_to_out) begin
            out_data_reg <= int_data;
            out_keep_reg <= int_keep;
            out_last_reg <= int_last;
        end else if (tmp_to_out) begin
            out_data_reg <= tmp_data_reg;
            out_keep_reg <= tmp_keep_reg;
            out_last_reg <= tmp_last_reg;
        end
        if (int_to_tmp) begin
            tmp_data_reg <= int_data;
            tmp_keep_reg <= int_keep;
            tmp_last_reg <= int_last;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mac_ctrl_pkg.sv
// MAC control transmitter package: scheduler state and control opcode types
`default_nettype none

`include "mac_ctrl_settings.svh"

package mac_ctrl_pkg;

    // frame scheduler states
    // idle sits between frames, pause is only granted here
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_DATA = 2'd1,
        ST_MCF  = 2'd2
    } sched_state_t;

    // MAC control opcodes
    // 802.3x pause and 802.1Qbb priority flow control
    typedef enum logic [`MCF_TYPE_W-1:0] {
        OP_PAUSE = 16'h0001,
        OP_PFC   = 16'h0101
    } mcf_opcode_t;

endpackage

`default_nettype wire

// File: hdl/mac_ctrl_settings.svh
// MAC control transmitter settings: stream widths and control frame layout sizes
`ifndef MAC_CTRL_SETTINGS_SVH
`define MAC_CTRL_SETTINGS_SVH

// stream data path
`define MCF_DATA_W 64
`define MCF_KEEP_W 8

// control frame length in bytes, minimum frame without FCS
`define MCF_HDR_SIZE 60

// parameter bytes carried after the opcode
`define MCF_PARAMS_SIZE 18

// beats per control frame at 8 lanes
`define MCF_CYCLE_CNT 8

// beat pointer width
`define MCF_PTR_W 4

// header field widths
`define MCF_MAC_W 48
`define MCF_TYPE_W 16

`endif

// File: hdl/mac_ctrl_tx.sv
// MAC control transmitter top: merges serialized control frames into the data stream
`timescale 1ns/1ps
`default_nettype none

`include "mac_ctrl_settings.svh"

module mac_ctrl_tx (
    input  wire logic                          clk,
    input  wire logic                          rst,

    // data stream input
    input  wire logic [`MCF_DATA_W-1:0]        s_axis_tdata,
    input  wire logic [`MCF_KEEP_W-1:0]        s_axis_tkeep,
    input  wire logic                          s_axis_tvalid,
    output logic                               s_axis_tready,
    input  wire logic                          s_axis_tlast,

    // merged stream output
    output logic [`MCF_DATA_W-1:0]             m_axis_tdata,
    output logic [`MCF_KEEP_W-1:0]             m_axis_tkeep,
    output logic                               m_axis_tvalid,
    input  wire logic                          m_axis_tready,
    output logic                               m_axis_tlast,

    // control frame request
    input  wire logic                          mcf_valid,
    output logic                               mcf_ready,
    input  wire logic [`MCF_MAC_W-1:0]         mcf_eth_dst,
    input  wire logic [`MCF_MAC_W-1:0]         mcf_eth_src,
    input  wire logic [`MCF_TYPE_W-1:0]        mcf_eth_type,
    input  wire mac_ctrl_pkg::mcf_opcode_t     mcf_opcode,
    input  wire logic [`MCF_PARAMS_SIZE*8-1:0] mcf_params,

    // pause and status
    input  wire logic                          tx_pause_req,
    output logic                               tx_pause_ack,
    output logic                               stat_tx_mcf
);

    // serializer link
    logic [`MCF_DATA_W-1:0] beat_data;
    logic [`MCF_KEEP_W-1:0] beat_keep;
    logic                   beat_last;
    logic                   beat_penult;
    logic                   mcf_start;
    logic                   mcf_advance;

    // scheduler to skid buffer
    logic [`MCF_DATA_W-1:0] int_data;
    logic [`MCF_KEEP_W-1:0] int_keep;
    logic                   int_valid;
    logic                   int_last;
    logic                   ready_early;
    logic                   ready_reg;

    mcf_tx_scheduler sched0 (
        .clk           (clk),
        .rst           (rst),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .s_axis_tlast  (s_axis_tlast),
        .mcf_valid     (mcf_valid),
        .mcf_ready     (mcf_ready),
        .tx_pause_req  (tx_pause_req),
        .tx_pause_ack  (tx_pause_ack),
        .stat_tx_mcf   (stat_tx_mcf),
        .beat_data     (beat_data),
        .beat_keep     (beat_keep),
        .beat_last     (beat_last),
        .beat_penult   (beat_penult),
        .mcf_start     (mcf_start),
        .mcf_advance   (mcf_advance),
        .int_data      (int_data),
        .int_keep      (int_keep),
        .int_valid     (int_valid),
        .int_last      (int_last),
        .ready_early   (ready_early),
        .ready_reg     (ready_reg)
    );

    mcf_serializer ser0 (
        .clk          (clk),
        .rst          (rst),
        .mcf_start    (mcf_start),
        .mcf_advance  (mcf_advance),
        .mcf_eth_dst  (mcf_eth_dst),
        .mcf_eth_src  (mcf_eth_src),
        .mcf_eth_type (mcf_eth_type),
        .mcf_opcode   (mcf_opcode),
        .mcf_params   (mcf_params),
        .beat_data    (beat_data),
        .beat_keep    (beat_keep),
        .beat_last    (beat_last),
        .beat_penult  (beat_penult)
    );

    axis_skid_buffer skid0 (
        .clk           (clk),
        .rst           (rst),
        .int_data      (int_data),
        .int_keep      (int_keep),
        .int_valid     (int_valid),
        .int_last      (int_last),
        .ready_early   (ready_early),
        .ready_reg     (ready_reg),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast)
    );

endmodule

`default_nettype wire

// File: hdl/mcf_serializer.sv
// MAC control frame serializer: places the 60-byte control header onto 64-bit beats
`timescale 1ns/1ps
`default_nettype none

`include "mac_ctrl_settings.svh"

module mcf_serializer (
    input  wire logic                          clk,
    input  wire logic                          rst,

    // pointer control from the scheduler
    input  wire logic                          mcf_start,
    input  wire logic                          mcf_advance,

    // control frame fields, held stable by the source
    input  wire logic [`MCF_MAC_W-1:0]         mcf_eth_dst,
    input  wire logic [`MCF_MAC_W-1:0]         mcf_eth_src,
    input  wire logic [`MCF_TYPE_W-1:0]        mcf_eth_type,
    input  wire mac_ctrl_pkg::mcf_opcode_t     mcf_opcode,
    input  wire logic [`MCF_PARAMS_SIZE*8-1:0] mcf_params,

    // current beat
    output logic [`MCF_DATA_W-1:0]             beat_data,
    output logic [`MCF_KEEP_W-1:0]             beat_keep,
    output logic                               beat_last,
    output logic                               beat_penult
);

    logic [`MCF_PTR_W-1:0]      ptr_reg;
    logic [`MCF_TYPE_W-1:0]     opcode_bits;

    // whole header, byte i at bits [i*8 +: 8]
    logic [`MCF_HDR_SIZE*8-1:0] hdr;

    assign opcode_bits = mcf_opcode;

    always_comb begin
        hdr = '0;
        // addresses go out most significant byte first
        for (int i = 0; i < 6; i++) begin
            hdr[i*8 +: 8]     = mcf_eth_dst[(5-i)*8 +: 8];
            hdr[(6+i)*8 +: 8] = mcf_eth_src[(5-i)*8 +: 8];
        end
        hdr[12*8 +: 8] = mcf_eth_type[15:8];
        hdr[13*8 +: 8] = mcf_eth_type[7:0];
        hdr[14*8 +: 8] = opcode_bits[15:8];
        hdr[15*8 +: 8] = opcode_bits[7:0];
        // params in byte order, remainder stays as padding
        for (int k = 0; k < `MCF_PARAMS_SIZE; k++) begin
            hdr[(16+k)*8 +: 8] = mcf_params[k*8 +: 8];
        end
    end

    // lane l of beat p holds header byte p*8+l
    always_comb begin
        int unsigned off;

        beat_data = '0;
        beat_keep = '0;
        for (int l = 0; l < `MCF_KEEP_W; l++) begin
            off = {ptr_reg, 3'b000} + l;
            if (off < `MCF_HDR_SIZE) begin
                beat_data[l*8 +: 8] = hdr[off*8 +: 8];
                beat_keep[l]        = 1'b1;
            end
        end
    end

    assign beat_last   = (ptr_reg == `MCF_PTR_W'(`MCF_CYCLE_CNT-1));
    assign beat_penult = (ptr_reg == `MCF_PTR_W'(`MCF_CYCLE_CNT-2));

    // start wins over advance, pointer holds otherwise
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_reg <= '0;
        end else if (mcf_start) begin
            ptr_reg <= '0;
        end else if (mcf_advance) begin
            ptr_reg <= ptr_reg + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mcf_tx_scheduler.sv
// MAC control frame scheduler: merges data and control frames, drives readies and pause
`timescale 1ns/1ps
`default_nettype none

`include "mac_ctrl_settings.svh"

module mcf_tx_scheduler (
    input  wire logic                   clk,
    input  wire logic                   rst,

    // data frame input
    input  wire logic [`MCF_DATA_W-1:0] s_axis_tdata,
    input  wire logic [`MCF_KEEP_W-1:0] s_axis_tkeep,
    input  wire logic                   s_axis_tvalid,
    output logic                        s_axis_tready,
    input  wire logic                   s_axis_tlast,

    // control frame handshake
    input  wire logic                   mcf_valid,
    output logic                        mcf_ready,

    // pause and status
    input  wire logic                   tx_pause_req,
    output logic                        tx_pause_ack,
    output logic                        stat_tx_mcf,

    // serializer link
    input  wire logic [`MCF_DATA_W-1:0] beat_data,
    input  wire logic [`MCF_KEEP_W-1:0] beat_keep,
    input  wire logic                   beat_last,
    input  wire logic                   beat_penult,
    output logic                        mcf_start,
    output logic                        mcf_advance,

    // beats towards the skid buffer
    output logic [`MCF_DATA_W-1:0]      int_data,
    output logic [`MCF_KEEP_W-1:0]      int_keep,
    output logic                        int_valid,
    output logic                        int_last,
    input  wire logic                   ready_early,
    input  wire logic                   ready_reg
);

    mac_ctrl_pkg::sched_state_t state_reg, state_next;

    logic s_axis_tready_reg, s_axis_tready_next;
    logic mcf_ready_reg, mcf_ready_next;
    logic tx_pause_ack_reg, tx_pause_ack_next;
    logic stat_tx_mcf_reg, stat_tx_mcf_next;

    // data beat handshake on the input side
    logic data_xfer;

    assign data_xfer = s_axis_tvalid && s_axis_tready_reg;

    assign s_axis_tready = s_axis_tready_reg;
    assign mcf_ready     = mcf_ready_reg;
    assign tx_pause_ack  = tx_pause_ack_reg;
    assign stat_tx_mcf   = stat_tx_mcf_reg;

    always_comb begin
        state_next         = state_reg;
        s_axis_tready_next = 1'b0;
        mcf_ready_next     = 1'b0;
        tx_pause_ack_next  = tx_pause_ack_reg;
        stat_tx_mcf_next   = 1'b0;
        mcf_start          = 1'b0;
        mcf_advance        = 1'b0;

        // data passes through by default, valid only on a real transfer
        int_data  = s_axis_tdata;
        int_keep  = s_axis_tkeep;
        int_valid = 1'b0;
        int_last  = s_axis_tlast;

        case (state_reg)
            mac_ctrl_pkg::ST_IDLE: begin
                // frame boundary, pause may hold off new data
                s_axis_tready_next = ready_early && !tx_pause_req;
                tx_pause_ack_next  = tx_pause_req;
                if (data_xfer) begin
                    s_axis_tready_next = ready_early;
                    tx_pause_ack_next  = 1'b0;
                    int_valid          = 1'b1;
                    if (s_axis_tlast) begin
                        // single beat frame, give a waiting control frame its turn
                        s_axis_tready_next = ready_early && !tx_pause_req && !mcf_valid;
                    end else begin
                        state_next = mac_ctrl_pkg::ST_DATA;
                    end
                end else if (mcf_valid) begin
                    s_axis_tready_next = 1'b0;
                    mcf_start          = 1'b1;
                    state_next         = mac_ctrl_pkg::ST_MCF;
                end
            end
            mac_ctrl_pkg::ST_DATA: begin
                s_axis_tready_next = ready_early;
                if (data_xfer) begin
                    int_valid = 1'b1;
                    if (s_axis_tlast) begin
                        s_axis_tready_next = ready_early && !tx_pause_req;
                        state_next         = mac_ctrl_pkg::ST_IDLE;
                        if (mcf_valid) begin
                            // control frame follows straight after this one
                            s_axis_tready_next = 1'b0;
                            mcf_start          = 1'b1;
                            state_next         = mac_ctrl_pkg::ST_MCF;
                        end
                    end
                end
            end
            mac_ctrl_pkg::ST_MCF: begin
                int_data  = beat_data;
                int_keep  = beat_keep;
                int_last  = 1'b0;
                // last beat held back, ready pulse lines up with its acceptance
                mcf_ready_next = beat_last && ready_early;
                if (ready_reg) begin
                    mcf_advance = 1'b1;
                    int_valid   = 1'b1;
                    if (beat_last) begin
                        int_last           = 1'b1;
                        mcf_ready_next     = 1'b0;
                        stat_tx_mcf_next   = 1'b1;
                        s_axis_tready_next = ready_early && !tx_pause_req;
                        // back at a boundary, ack tracks the request with the ready
                        tx_pause_ack_next  = tx_pause_req;
                        state_next         = mac_ctrl_pkg::ST_IDLE;
                    end else begin
                        // pointer moves to the last beat on this edge
                        mcf_ready_next = beat_penult && ready_early;
                    end
                end
            end
            default: begin
                state_next = mac_ctrl_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg         <= mac_ctrl_pkg::ST_IDLE;
            s_axis_tready_reg <= 1'b0;
            mcf_ready_reg     <= 1'b0;
            tx_pause_ack_reg  <= 1'b0;
            stat_tx_mcf_reg   <= 1'b0;
        end else begin
            state_reg         <= state_next;
            s_axis_tready_reg <= s_axis_tready_next;
            mcf_ready_reg     <= mcf_ready_next;
            tx_pause_ack_reg  <= tx_pause_ack_next;
            stat_tx_mcf_reg   <= stat_tx_mcf_next;
        end
    end

endmodule

`default_nettype wire

// File: mac_ctrl_tx.f
+incdir+hdl
hdl/mac_ctrl_pkg.sv
hdl/mcf_tx_scheduler.sv
hdl/mcf_serializer.sv
hdl/axis_skid_buffer.sv
hdl/mac_ctrl_tx.sv
tests/tb_mac_ctrl_tx.sv

// File: run_sim.sh
#!/bin/sh
# build and run the MAC control transmitter testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f mac_ctrl_tx.f --top-module tb_mac_ctrl_tx -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -F "*** PASSED ***" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tests/tb_mac_ctrl_tx.sv
// MAC control transmitter testbench: random data and control frames checked against a queue model
`timescale 1ns/1ps
`default_nettype none

`include "mac_ctrl_settings.svh"

module tb_mac_ctrl_tx;

    // stimulus sizes
    localparam int n_data_frames = 40;
    localparam int max_beats     = 12;
    localparam int n_mcf_frames  = 30;
    // worst case beats times back-pressure factor, plus margin
    localparam int timeout_cycles =
        (n_data_frames * max_beats + n_mcf_frames * `MCF_CYCLE_CNT) * 4 + 3000;

    localparam logic [47:0] pause_dst  = 48'h0180_c200_0001;
    localparam logic [15:0] ctrl_etype = 16'h8808;

    logic                          clk;
    logic                          rst;
    logic [`MCF_DATA_W-1:0]        s_axis_tdata;
    logic [`MCF_KEEP_W-1:0]        s_axis_tkeep;
    logic                          s_axis_tvalid;
    logic                          s_axis_tready;
    logic                          s_axis_tlast;
    logic [`MCF_DATA_W-1:0]        m_axis_tdata;
    logic [`MCF_KEEP_W-1:0]        m_axis_tkeep;
    logic                          m_axis_tvalid;
    logic                          m_axis_tready;
    logic                          m_axis_tlast;
    logic                          mcf_valid;
    logic                          mcf_ready;
    logic [`MCF_MAC_W-1:0]         mcf_eth_dst;
    logic [`MCF_MAC_W-1:0]         mcf_eth_src;
    logic [`MCF_TYPE_W-1:0]        mcf_eth_type;
    mac_ctrl_pkg::mcf_opcode_t     mcf_opcode;
    logic [`MCF_PARAMS_SIZE*8-1:0] mcf_params;
    logic                          tx_pause_req;
    logic                          tx_pause_ack;
    logic                          stat_tx_mcf;

    // expected beats as {last, keep, data}
    logic [72:0] data_q[$];
    logic [72:0] ctrl_q[$];
    // beats of the output frame in progress
    logic [72:0] out_frame[$];

    int cycle_cnt;
    int gen_frames;
    int gen_beat;
    int gen_len;
    int mcf_issued;
    int mcf_done;
    int stat_cnt;
    int data_out_cnt;
    int ctrl_out_cnt;

    mac_ctrl_tx dut0 (
        .clk           (clk),
        .rst           (rst),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .s_axis_tlast  (s_axis_tlast),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast),
        .mcf_valid     (mcf_valid),
        .mcf_ready     (mcf_ready),
        .mcf_eth_dst   (mcf_eth_dst),
        .mcf_eth_src   (mcf_eth_src),
        .mcf_eth_type  (mcf_eth_type),
        .mcf_opcode    (mcf_opcode),
        .mcf_params    (mcf_params),
        .tx_pause_req  (tx_pause_req),
        .tx_pause_ack  (tx_pause_ack),
        .stat_tx_mcf   (stat_tx_mcf)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("scheduler state %s", dut0.sched0.state_reg.name());
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    // expected control frame from the header layout, fields as held by the source
    task automatic push_ctrl_frame();
        logic [7:0]  hdr [0:59];
        logic [63:0] bd;
        logic [7:0]  bk;
        logic [15:0] op;
        int          off;

        op = mcf_opcode;
        for (int i = 0; i < 60; i++) begin
            hdr[i] = 8'h00;
        end
        // addresses most significant byte first
        for (int i = 0; i < 6; i++) begin
            hdr[i]   = mcf_eth_dst[47-8*i -: 8];
            hdr[6+i] = mcf_eth_src[47-8*i -: 8];
        end
        hdr[12] = mcf_eth_type[15:8];
        hdr[13] = mcf_eth_type[7:0];
        hdr[14] = op[15:8];
        hdr[15] = op[7:0];
        for (int k = 0; k < 18; k++) begin
            hdr[16+k] = mcf_params[k*8 +: 8];
        end
        for (int b = 0; b < 8; b++) begin
            bd = '0;
            bk = '0;
            for (int l = 0; l < 8; l++) begin
                off = b * 8 + l;
                if (off < 60) begin
                    bd[l*8 +: 8] = hdr[off];
                    bk[l]        = 1'b1;
                end
            end
            ctrl_q.push_back({b == 7, bk, bd});
        end
    endtask

    // data source, valid held until accepted
    task automatic drive_data_input();
        logic        accepted;
        logic [63:0] d;
        logic        last;

        accepted = s_axis_tvalid && s_axis_tready;
        if (accepted) begin
            data_q.push_back({s_axis_tlast, s_axis_tkeep, s_axis_tdata});
            // no data may pass while the pause is granted
            if (tx_pause_ack) begin
                fail_run("data beat accepted while pause acknowledged");
            end
        end
        if (accepted || !s_axis_tvalid) begin
            if (gen_frames < n_data_frames && ($urandom % 10) < 8) begin
                if (gen_beat == 0) begin
                    gen_len = 1 + int'($urandom % max_beats);
                end
                d = {$urandom, $urandom};
                // even first byte, never mistaken for a control frame
                if (gen_beat == 0) begin
                    d[0] = 1'b0;
                end
                last = (gen_beat == gen_len - 1);
                s_axis_tdata  <= d;
                s_axis_tkeep  <= last ? (8'hff >> ($urandom % 8)) : 8'hff;
                s_axis_tlast  <= last;
                s_axis_tvalid <= 1'b1;
                gen_beat = gen_beat + 1;
                if (last) begin
                    gen_beat   = 0;
                    gen_frames = gen_frames + 1;
                end
            end else begin
                s_axis_tvalid <= 1'b0;
            end
        end
    endtask

    // control requests held until mcf_ready
    task automatic drive_control_request();
        if (mcf_ready && !mcf_valid) begin
            fail_run("mcf_ready pulsed with no pending control frame");
        end
        if (mcf_valid && mcf_ready) begin
            push_ctrl_frame();
            mcf_done = mcf_done + 1;
            mcf_valid <= 1'b0;
        end else if (!mcf_valid && mcf_issued < n_mcf_frames && ($urandom % 40) == 0) begin
            mcf_eth_src <= {16'($urandom), $urandom};
            mcf_opcode  <= (($urandom % 2) == 0) ? mac_ctrl_pkg::OP_PAUSE
                                                 : mac_ctrl_pkg::OP_PFC;
            for (int k = 0; k < 18; k++) begin
                mcf_params[k*8 +: 8] <= 8'($urandom);
            end
            mcf_valid  <= 1'b1;
            mcf_issued = mcf_issued + 1;
        end
    endtask

    // collect output beats, compare a whole frame at tlast
    task automatic watch_output();
        logic        is_ctrl;
        logic [72:0] exp;
        logic [72:0] act;
        string       tag;

        if (stat_tx_mcf) begin
            stat_cnt = stat_cnt + 1;
        end
        if (m_axis_tvalid && m_axis_tready) begin
            out_frame.push_back({m_axis_tlast, m_axis_tkeep, m_axis_tdata});
            if (m_axis_tlast) begin
                // destination 01:80:C2... marks a control frame
                is_ctrl = (out_frame[0][7:0] == 8'h01);
                for (int i = 0; i < out_frame.size(); i++) begin
                    if (is_ctrl && ctrl_q.size() == 0) begin
                        fail_run("control frame on output with none expected");
                    end
                    if (!is_ctrl && data_q.size() == 0) begin
                        fail_run("data frame on output with none expected");
                    end
                    exp = is_ctrl ? ctrl_q.pop_front() : data_q.pop_front();
                    act = out_frame[i];
                    tag = is_ctrl ? $sformatf("ctrl frame %0d beat %0d", ctrl_out_cnt, i)
                                  : $sformatf("data frame %0d beat %0d", data_out_cnt, i);
                    check_value({tag, " tdata"}, exp[63:0], act[63:0]);
                    check_value({tag, " tkeep"}, 64'(exp[71:64]), 64'(act[71:64]));
                    check_value({tag, " tlast"}, 64'(exp[72]), 64'(act[72]));
                end
                if (is_ctrl) begin
                    ctrl_out_cnt = ctrl_out_cnt + 1;
                end else begin
                    data_out_cnt = data_out_cnt + 1;
                end
                out_frame.delete();
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (!rst) begin
            watch_output();
            drive_data_input();
            drive_control_request();
            // random pause and output back-pressure
            if (($urandom % 16) == 0) begin
                tx_pause_req <= !tx_pause_req;
            end
            m_axis_tready <= (($urandom % 10) >= 3);
        end
    end

    function automatic logic all_done();
        return gen_frames == n_data_frames && !s_axis_tvalid &&
               mcf_done == n_mcf_frames && !mcf_valid &&
               data_q.size() == 0 && ctrl_q.size() == 0 && out_frame.size() == 0;
    endfunction

    initial begin
        void'($urandom(32'h5b51_815f));
        rst           = 1'b1;
        s_axis_tdata  = '0;
        s_axis_tkeep  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        m_axis_tready = 1'b0;
        mcf_valid     = 1'b0;
        mcf_eth_dst   = pause_dst;
        mcf_eth_src   = '0;
        mcf_eth_type  = ctrl_etype;
        mcf_opcode    = mac_ctrl_pkg::OP_PAUSE;
        mcf_params    = '0;
        tx_pause_req  = 1'b0;
        cycle_cnt     = 0;
        gen_frames    = 0;
        gen_beat      = 0;
        gen_len       = 1;
        mcf_issued    = 0;
        mcf_done      = 0;
        stat_cnt      = 0;
        data_out_cnt  = 0;
        ctrl_out_cnt  = 0;

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        // values still from reset on this edge
        check_value("reset s_axis_tready", 64'd0, 64'(s_axis_tready));
        check_value("reset mcf_ready", 64'd0, 64'(mcf_ready));
        check_value("reset tx_pause_ack", 64'd0, 64'(tx_pause_ack));
        check_value("reset stat_tx_mcf", 64'd0, 64'(stat_tx_mcf));
        check_value("reset m_axis_tvalid", 64'd0, 64'(m_axis_tvalid));

        while (!all_done()) begin
            @(posedge clk);
            if (cycle_cnt >= timeout_cycles) begin
                fail_run("timeout waiting for all frames to leave the DUT");
            end
        end
        // room for the last status pulse
        repeat (8) @(posedge clk);

        if (data_q.size() == 0 && ctrl_q.size() == 0 && stat_cnt == mcf_done) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            fail_run($sformatf("end state wrong, stat pulses %0d for %0d control frames",
                               stat_cnt, mcf_done));
        end
    end

endmodule

`default_nettype wire
